// File: rst_ctrl_top.f
+incdir+include
rtl/rst_ctrl_pkg.sv
rtl/rst_in_sync.sv
rtl/rst_step_timer.sv
rtl/rst_domain_sequencer.sv
rtl/rst_ctrl_regs.sv
rtl/rst_ctrl_top.sv
verification/tb_clk_gen.sv
verification/rst_ctrl_chk.sv
verification/rst_ctrl_tb.sv

// File: verification/rst_ctrl_tb.sv
`timescale 1ns/1ps
`include "rst_ctrl_macros.svh"

module rst_ctrl_tb;
	import rst_ctrl_pkg::*;

	localparam int          STEP_CYCLES    = 1 << `RST_TIMER_BW;
	localparam int          N_DOM          = `RST_N_DOMAINS;
	// Six tests, none longer than about ten settle periods
	localparam int          TIMEOUT_CYCLES = 6 * 10 * STEP_CYCLES;
	localparam logic [31:0] ALL_DOMAINS    = (32'd1 << N_DOM) - 32'd1;
	// SEQ reads ones above the stage bits
	localparam logic [31:0] SEQ_FILL       = ~ALL_DOMAINS;

	logic                    rvx_port_11;
	logic                    rvx_signal_05;
	logic                    pwr_ok;
	boot_mode_e              boot_mode;
	logic                    force_run;
	reg_req_t                req;
	logic [`RST_DATA_BW-1:0] rdata;
	logic                    err;
	logic                    sys_rst_n;
	logic [N_DOM-1:0]        domain_rst_n;
	logic                    all_released;

	int unsigned      cyc = 0;
	int unsigned      rel_cyc;
	int unsigned      n_checks = 0;
	int unsigned      n_errors = 0;
	logic [N_DOM-1:0] mask_val;

	tb_clk_gen #(.PERIOD_NS(100)) u_clk (.rvx_port_11(rvx_port_11));

	rst_ctrl_top u_dut (.*);

	bind rst_domain_sequencer rst_ctrl_chk u_chk
	(
		.rvx_port_11   (rvx_port_11),
		.rvx_signal_05 (rvx_signal_05),
		.stage         (stage),
		.step          (step),
		.all_released  (all_released)
	);

	always @(posedge rvx_port_11)
	begin
		cyc <= cyc + 1;
	end

	// ************************************************************
	// Checking and bus helpers
	// ************************************************************
	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
		n_checks++;
		assert (got === exp)
		else
		begin
			n_errors++;
			$display("ERR %s: got 0x%0h, expected 0x%0h", name, got, exp);
		end
	endtask

	task automatic check_cond(input logic ok, input string what);
		n_checks++;
		assert (ok)
		else
		begin
			n_errors++;
			$display("Error: %s", what);
		end
	endtask

	task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
		@(posedge rvx_port_11);
		req <= '{sel: 1'b1, write: 1'b1, addr: addr, wdata: data};
		@(posedge rvx_port_11);
		req <= '0;
	endtask

	task automatic check_read(input logic [7:0] addr, input logic [31:0] exp_data,
		input logic exp_err);
		@(posedge rvx_port_11);
		req <= '{sel: 1'b1, write: 1'b0, addr: addr, wdata: 32'h0};
		@(negedge rvx_port_11);
		check_val($sformatf("rdata[0x%02h]", addr), rdata, exp_data);
		check_val($sformatf("err[0x%02h]", addr), err, exp_err);
		@(posedge rvx_port_11);
		req <= '0;
	endtask

	// Board reset for 4 cycles, core reset must follow two edges after release
	task automatic drive_reset(input boot_mode_e mode);
		@(posedge rvx_port_11);
		rvx_signal_05 <= 1'b0;
		boot_mode     <= mode;
		repeat (4) @(posedge rvx_port_11);
		rvx_signal_05 <= 1'b1;
		@(negedge rvx_port_11);
		check_val("sys_rst_n", sys_rst_n, 0);
		@(negedge rvx_port_11);
		check_val("sys_rst_n", sys_rst_n, 0);
		@(negedge rvx_port_11);
		check_val("sys_rst_n", sys_rst_n, 1);
		check_val("domain_rst_n", domain_rst_n, 0);
		check_val("all_released", all_released, 0);
		rel_cyc = cyc;
	endtask

	// ************************************************************
	// Tests
	// ************************************************************
	task automatic test_stand_alone();
		int unsigned exp_cyc;
		drive_reset(STAND_ALONE);
		for (int i = 0; i < N_DOM; i++)
		begin
			do
				@(negedge rvx_port_11);
			while (!domain_rst_n[i]);
			// One START cycle, then one settle period per domain
			exp_cyc = 1 + STEP_CYCLES * (i + 1);
			check_cond(cyc - rel_cyc == exp_cyc, $sformatf(
				"domain %0d released %0d cycles after reset, expected %0d",
				i, cyc - rel_cyc, exp_cyc));
			check_val("domain_rst_n", domain_rst_n, (32'd1 << (i + 1)) - 1);
		end
		check_val("all_released", all_released, 1);
		check_read(`RST_OFS_SEQ, 32'hffff_ffff, 0);
	endtask

	task automatic test_hold();
		logic        held;
		int unsigned t;
		held = 1'b1;
		drive_reset(HOLD);
		repeat (300)
		begin
			@(negedge rvx_port_11);
			if (domain_rst_n != '0)
				held = 1'b0;
		end
		check_cond(held, "a domain left reset in HOLD mode");
		write_reg(`RST_OFS_CMD, NEXT_STEP);
		@(negedge rvx_port_11);
		t = cyc;
		do
			@(negedge rvx_port_11);
		while (!domain_rst_n[0]);
		check_cond(cyc - t == STEP_CYCLES, "NEXT_STEP release took the wrong number of cycles");
		check_val("domain_rst_n", domain_rst_n, 1);
		check_read(`RST_OFS_CMD, IDLE, 0);
		repeat (STEP_CYCLES + 8) @(negedge rvx_port_11);
		check_val("domain_rst_n", domain_rst_n, 1);
		write_reg(`RST_OFS_CMD, AUTO_INCR);
		do
			@(negedge rvx_port_11);
		while (!all_released);
		check_val("domain_rst_n", domain_rst_n, ALL_DOMAINS);
		check_read(`RST_OFS_CMD, IDLE, 0);
	endtask

	task automatic test_next_when_done();
		write_reg(`RST_OFS_CMD, NEXT_STEP);
		check_read(`RST_OFS_CMD, IDLE_WITH_ERROR, 0);
		// Low address bits are ignored
		check_read(8'h05, 0, 0);
		check_read(8'h0c, 0, 1);
	endtask

	task automatic test_mask();
		logic [31:0] data;
		data     = $urandom;
		mask_val = data[N_DOM-1:0];
		drive_reset(HOLD);
		write_reg(`RST_OFS_MASK, data);
		@(negedge rvx_port_11);
		check_val("domain_rst_n", domain_rst_n, mask_val);
		check_read(`RST_OFS_MASK, mask_val, 0);
		check_read(`RST_OFS_SEQ, SEQ_FILL, 0);
	endtask

	task automatic test_init();
		int unsigned t;
		write_reg(`RST_OFS_CMD, NEXT_STEP);
		repeat (STEP_CYCLES + 2) @(negedge rvx_port_11);
		check_read(`RST_OFS_SEQ, SEQ_FILL | 32'd1, 0);
		@(posedge rvx_port_11);
		boot_mode <= STAND_ALONE;
		write_reg(`RST_OFS_CMD, INIT);
		repeat (2) @(negedge rvx_port_11);
		check_val("domain_rst_n", domain_rst_n, mask_val);
		t = cyc;
		do
			@(negedge rvx_port_11);
		while (!all_released);
		check_cond(cyc - t == STEP_CYCLES * N_DOM, "sequence after INIT took the wrong time");
		check_val("domain_rst_n", domain_rst_n, ALL_DOMAINS);
	endtask

	task automatic test_debug_power();
		write_reg(`RST_OFS_MASK, 0);
		@(posedge rvx_port_11);
		boot_mode <= DEBUG;
		write_reg(`RST_OFS_CMD, INIT);
		repeat (2) @(negedge rvx_port_11);
		check_val("domain_rst_n", domain_rst_n, 0);
		do
			@(negedge rvx_port_11);
		while (!domain_rst_n[0]);
		repeat (2 * STEP_CYCLES) @(negedge rvx_port_11);
		check_val("domain_rst_n", domain_rst_n, 1);
		@(posedge rvx_port_11);
		force_run <= 1'b1;
		do
			@(negedge rvx_port_11);
		while (!all_released);
		check_val("domain_rst_n", domain_rst_n, ALL_DOMAINS);
		// Power loss must hit every reset before the next edge
		@(posedge rvx_port_11);
		pwr_ok <= 1'b0;
		@(negedge rvx_port_11);
		check_val("sys_rst_n", sys_rst_n, 0);
		check_val("domain_rst_n", domain_rst_n, 0);
		check_val("all_released", all_released, 0);
	endtask

	// ************************************************************
	// Run control
	// ************************************************************
	initial
	begin
		rvx_signal_05 = 1'b0;
		pwr_ok        = 1'b1;
		boot_mode     = STAND_ALONE;
		force_run     = 1'b0;
		req           = '0;
		void'($urandom(32'hd759_a6c7));
		test_stand_alone();
		test_hold();
		test_next_when_done();
		test_mask();
		test_init();
		test_debug_power();
		$display("Checks: %0d, check errors: %0d, assertion failures: %0d",
			n_checks, n_errors, u_dut.u_seq.u_chk.fail_count);
		if (n_errors == 0 && u_dut.u_seq.u_chk.fail_count == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

	initial
	begin
		while (cyc < TIMEOUT_CYCLES)
			@(posedge rvx_port_11);
		$display("Timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("Checks: %0d, check errors: %0d", n_checks, n_errors);
		$display("Verification failed");
		$finish;
	end

endmodule

// File: verification/rst_ctrl_chk.sv
`timescale 1ns/1ps
`include "rst_ctrl_macros.svh"

module rst_ctrl_chk
(
	input logic                      rvx_port_11,
	input logic                      rvx_signal_05,
	input logic [`RST_N_DOMAINS-1:0] stage,
	input logic                      step,
	input logic                      all_released
);

	int unsigned fail_count = 0;

	// Stage fills from bit 0 upward with no gaps
	a_stage_order: assert property (@(posedge rvx_port_11) disable iff (!rvx_signal_05)
		(stage[`RST_N_DOMAINS-1:1] & ~stage[`RST_N_DOMAINS-2:0]) == '0)
	else
	begin
		fail_count++;
		$error("stage bit set above a domain still held in reset");
	end

	// Nothing left to release once the last domain is out
	a_no_step_done: assert property (@(posedge rvx_port_11) disable iff (!rvx_signal_05)
		!(step && all_released))
	else
	begin
		fail_count++;
		$error("step fired with all domains released");
	end

	a_all_released: assert property (@(posedge rvx_port_11) disable iff (!rvx_signal_05)
		all_released == stage[`RST_N_DOMAINS-1])
	else
	begin
		fail_count++;
		$error("all_released differs from the last stage bit");
	end

endmodule

// File: verification/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen
#(
	parameter int PERIOD_NS = 100
)
(
	output logic rvx_port_11
);

	initial
	begin
		rvx_port_11 = 1'b0;
	end

	always
	begin
		#(PERIOD_NS / 2) rvx_port_11 = ~rvx_port_11;
	end

endmodule

// File: rtl/rst_ctrl_top.sv
`timescale 1ns/1ps
`include "rst_ctrl_macros.svh"

module rst_ctrl_top
(
	input  logic                      rvx_port_11,
	input  logic                      rvx_signal_05,
	input  logic                      pwr_ok,
	input  rst_ctrl_pkg::boot_mode_e  boot_mode,
	input  logic                      force_run,
	input  rst_ctrl_pkg::reg_req_t    req,
	output logic [`RST_DATA_BW-1:0]   rdata,
	output logic                      err,
	output logic                      sys_rst_n,
	output logic [`RST_N_DOMAINS-1:0] domain_rst_n,
	output logic                      all_released
);
	import rst_ctrl_pkg::*;

	logic        core_rst_n;
	seq_ctrl_t   ctrl;
	seq_status_t status;

	// Synchronized core reset feeds every flop below
	rst_in_sync u_in_sync
	(
		.rvx_port_11   (rvx_port_11),
		.rvx_signal_05 (rvx_signal_05),
		.pwr_ok        (pwr_ok),
		.core_rst_n    (core_rst_n)
	);

	rst_ctrl_regs u_regs
	(
		.rvx_port_11   (rvx_port_11),
		.rvx_signal_05 (core_rst_n),
		.req           (req),
		.status        (status),
		.ctrl          (ctrl),
		.rdata         (rdata),
		.err           (err)
	);

	rst_domain_sequencer u_seq
	(
		.rvx_port_11   (rvx_port_11),
		.rvx_signal_05 (core_rst_n),
		.boot_mode     (boot_mode),
		.force_run     (force_run),
		.ctrl          (ctrl),
		.status        (status),
		.domain_rst_n  (domain_rst_n)
	);

	assign sys_rst_n    = core_rst_n;
	assign all_released = status.all_released;

endmodule

// File: rtl/rst_ctrl_regs.sv
`timescale 1ns/1ps
`include "rst_ctrl_macros.svh"

module rst_ctrl_regs
(
	input  logic                      rvx_port_11,
	input  logic                      rvx_signal_05,
	input  rst_ctrl_pkg::reg_req_t    req,
	input  rst_ctrl_pkg::seq_status_t status,
	output rst_ctrl_pkg::seq_ctrl_t   ctrl,
	output logic [`RST_DATA_BW-1:0]   rdata,
	output logic                      err
);
	import rst_ctrl_pkg::*;

	logic [`RST_ADDR_BW-1:0]   word_addr;
	logic                      wr_en;
	logic                      cmd_wr;
	logic                      mask_wr;
	logic                      last_step;
	rst_cmd_e                  cmd;
	logic [`RST_N_DOMAINS-1:0] mask;

	// Byte lanes are ignored
	assign word_addr = {req.addr[`RST_ADDR_BW-1:2], 2'b00};
	assign wr_en     = req.sel & req.write;
	assign cmd_wr    = wr_en & (word_addr == `RST_OFS_CMD);
	assign mask_wr   = wr_en & (word_addr == `RST_OFS_MASK);

	// Step that releases the last domain
	assign last_step = status.step & status.stage[`RST_N_DOMAINS-2];

	// ************************************************************
	// Command register
	// ************************************************************
	always_ff @(posedge rvx_port_11 or negedge rvx_signal_05)
	begin
		if (!rvx_signal_05)
		begin
			cmd <= IDLE;
		end
		else if (cmd_wr)
		begin
			cmd <= rst_cmd_e'(req.wdata[2:0]);
		end
		else if (cmd == NEXT_STEP && status.all_released)
		begin
			cmd <= IDLE_WITH_ERROR;
		end
		else
		begin
			case (cmd)
				INIT:      cmd <= IDLE;
				NEXT_STEP: if (status.step) cmd <= IDLE;
				AUTO_INCR: if (last_step) cmd <= IDLE;
				default:   cmd <= cmd;
			endcase
		end
	end

	// Force-release mask
	always_ff @(posedge rvx_port_11 or negedge rvx_signal_05)
	begin
		if (!rvx_signal_05)
		begin
			mask <= '0;
		end
		else if (mask_wr)
		begin
			mask <= req.wdata[`RST_N_DOMAINS-1:0];
		end
	end

	always_comb
	begin
		ctrl.restart  = (cmd == INIT);
		ctrl.cmd_step = (cmd == NEXT_STEP) || (cmd == AUTO_INCR);
		ctrl.mask     = mask;
	end

	// ************************************************************
	// Read path
	// ************************************************************
	always_comb
	begin
		rdata = '0;
		err   = 1'b0;
		case (word_addr)
			`RST_OFS_CMD:  rdata = `RST_DATA_BW'(cmd);
			`RST_OFS_MASK: rdata[`RST_N_DOMAINS-1:0] = mask;
			`RST_OFS_SEQ:
			begin
				// Unused upper bits read as released
				rdata = '1;
				rdata[`RST_N_DOMAINS-1:0] = status.stage;
			end
			default:       err = req.sel;
		endcase
	end

endmodule

// File: rtl/rst_domain_sequencer.sv
`timescale 1ns/1ps
`include "rst_ctrl_macros.svh"

module rst_domain_sequencer
(
	input  logic                      rvx_port_11,
	input  logic                      rvx_signal_05,
	input  rst_ctrl_pkg::boot_mode_e  boot_mode,
	input  logic                      force_run,
	input  rst_ctrl_pkg::seq_ctrl_t   ctrl,
	output rst_ctrl_pkg::seq_status_t status,
	output logic [`RST_N_DOMAINS-1:0] domain_rst_n
);
	import rst_ctrl_pkg::*;

	logic                      run;
	logic [`RST_N_DOMAINS-1:0] stage;
	logic                      all_released;
	logic                      auto_run;
	logic                      step_req;
	logic                      step;

	// ************************************************************
	// Phase and stage
	// ************************************************************

	// START for a single cycle after reset release, RUN afterwards
	always_ff @(posedge rvx_port_11 or negedge rvx_signal_05)
	begin
		if (!rvx_signal_05)
		begin
			run <= 1'b0;
		end
		else
		begin
			run <= 1'b1;
		end
	end

	// Released domains fill from bit 0 upward
	always_ff @(posedge rvx_port_11 or negedge rvx_signal_05)
	begin
		if (!rvx_signal_05)
		begin
			stage <= '0;
		end
		else if (ctrl.restart)
		begin
			stage <= '0;
		end
		else if (step)
		begin
			stage <= {stage[`RST_N_DOMAINS-2:0], 1'b1};
		end
	end

	assign all_released = stage[`RST_N_DOMAINS-1];

	// ************************************************************
	// Step request
	// ************************************************************

	// No pending command means IDLE, where the boot mode decides
	always_comb
	begin
		auto_run = 1'b0;
		if (!ctrl.restart && !ctrl.cmd_step)
		begin
			case (boot_mode)
				STAND_ALONE: auto_run = 1'b1;
				DEBUG:       auto_run = ~stage[0];
				HOLD:        auto_run = 1'b0;
				default:     auto_run = 1'b0;
			endcase
		end
	end

	assign step_req = run & ~ctrl.restart & ~all_released &
		(force_run | ctrl.cmd_step | auto_run);

	// Timer restarts whenever the request drops or a step completes
	rst_step_timer u_timer
	(
		.rvx_port_11   (rvx_port_11),
		.rvx_signal_05 (rvx_signal_05),
		.init          (~step_req | step),
		.count         (step_req),
		.last          (step)
	);

	// ************************************************************
	// Outputs
	// ************************************************************
	always_comb
	begin
		status.stage        = stage;
		status.step         = step;
		status.all_released = all_released;
	end

	// A mask bit holds its domain out of reset regardless of stage
	assign domain_rst_n = stage | ctrl.mask;

endmodule

// File: rtl/rst_step_timer.sv
`timescale 1ns/1ps
`include "rst_ctrl_macros.svh"

module rst_step_timer
(
	input  logic rvx_port_11,
	input  logic rvx_signal_05,
	input  logic init,
	input  logic count,
	output logic last
);

	logic [`RST_TIMER_BW-1:0] value;

	// init has priority, so the cycle that ends a step also restarts the count
	always_ff @(posedge rvx_port_11 or negedge rvx_signal_05)
	begin
		if (!rvx_signal_05)
		begin
			value <= '0;
		end
		else if (init)
		begin
			value <= '0;
		end
		else if (count)
		begin
			value <= value + 1'b1;
		end
	end

	// Last counted cycle of a settle period
	assign last = count & (&value);

endmodule

// File: rtl/rst_in_sync.sv
`timescale 1ns/1ps

module rst_in_sync
(
	input  logic rvx_port_11,
	input  logic rvx_signal_05,
	input  logic pwr_ok,
	output logic core_rst_n
);

	logic       arst_n;
	logic [1:0] sync_q;

	// Either board reset or loss of power pulls the core into reset
	assign arst_n = rvx_signal_05 & pwr_ok;

	// Assert at once, release two edges after both inputs are high
	always_ff @(posedge rvx_port_11 or negedge arst_n)
	begin
		if (!arst_n)
		begin
			sync_q <= 2'b00;
		end
		else
		begin
			sync_q <= {sync_q[0], 1'b1};
		end
	end

	assign core_rst_n = sync_q[1];

endmodule

// File: rtl/rst_ctrl_pkg.sv
`include "rst_ctrl_macros.svh"

package rst_ctrl_pkg;

	// Software commands held in the CMD register
	typedef enum logic [2:0]
	{
		IDLE            = 3'd0,
		INIT            = 3'd1,
		NEXT_STEP       = 3'd2,
		AUTO_INCR       = 3'd3,
		IDLE_WITH_ERROR = 3'd4
	} rst_cmd_e;

	// Board strap deciding how far the sequence runs on its own
	typedef enum logic [1:0]
	{
		STAND_ALONE = 2'd0,
		DEBUG       = 2'd1,
		HOLD        = 2'd2
	} boot_mode_e;

	// Single-cycle select/write strobe request
	typedef struct packed
	{
		logic                    sel;
		logic                    write;
		logic [`RST_ADDR_BW-1:0] addr;
		logic [`RST_DATA_BW-1:0] wdata;
	} reg_req_t;

	// Register block to sequencer
	typedef struct packed
	{
		logic                      restart;
		logic                      cmd_step;
		logic [`RST_N_DOMAINS-1:0] mask;
	} seq_ctrl_t;

	// Sequencer to register block
	typedef struct packed
	{
		logic [`RST_N_DOMAINS-1:0] stage;
		logic                      step;
		logic                      all_released;
	} seq_status_t;

endpackage

// File: include/rst_ctrl_macros.svh
`ifndef RST_CTRL_MACROS_SVH
`define RST_CTRL_MACROS_SVH

// ************************************************************
// Sizes
// ************************************************************

// Number of sequenced reset domains
`define RST_N_DOMAINS 4

// Settle timer width, one step is 2**RST_TIMER_BW cycles
`define RST_TIMER_BW 6

// Register bus widths
`define RST_DATA_BW 32
`define RST_ADDR_BW 8

// ************************************************************
// Register offsets
// ************************************************************
`define RST_OFS_CMD  8'h00
`define RST_OFS_MASK 8'h04
`define RST_OFS_SEQ  8'h08

`endif
